// ==== net_params.svh ====
`ifndef NET_PARAMS_SVH
`define NET_PARAMS_SVH

// IP protocol numbers
`define NET_PROTO_ICMP 8'd1
`define NET_PROTO_TCP 8'd6
`define NET_PROTO_UDP 8'd17

// tcp, udp, icmp
`define NET_NUM_CHANNELS 3

// payload bytes buffered per channel
`define NET_CHAN_FIFO_DEPTH 64

// APB register map
`define NET_REG_CTRL 8'h00
`define NET_REG_DROP 8'h04
`define NET_REG_CHAN_BASE 8'h10
`define NET_REG_CHAN_STRIDE 8'h08

`endif

// ==== net_pkg.sv ====
package net_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [7:0]  ip_proto_t;
    typedef logic [15:0] ip_len_t;
    typedef logic [7:0]  ip_ttl_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] counter_t;
    typedef logic [1:0]  chan_sel_t;   // 0 tcp, 1 udp, 2 icmp
    typedef logic [2:0]  chan_mask_t;  // one bit per channel

    // the subset of the IP header carried through the switch
    typedef struct packed {
        ip_proto_t protocol;
        ip_ttl_t   ttl;
        ip_len_t   length;
        ip_addr_t  source_ip;
        ip_addr_t  dest_ip;
    } ip_hdr_t;

    typedef struct packed {
        byte_t data;
        logic  last;
    } ip_beat_t;

    typedef struct packed {
        counter_t pkt_count;
        counter_t byte_count;
    } chan_stats_t;

    typedef enum logic [1:0] {IDLE, DELIVER, ROUTE, DROP} demux_state_t;

    typedef enum logic {HDR, PAYLOAD} arb_state_t;

endpackage

// ==== ip_proto_demux.sv ====
`timescale 1ns/100ps
`include "net_params.svh"

module ip_proto_demux (
    input  logic                i_clk,
    input  logic                i_reset,
    input  net_pkg::ip_hdr_t    i_rx_hdr,
    input  logic                i_rx_hdr_valid,
    output logic                o_rx_hdr_ready,
    input  net_pkg::ip_beat_t   i_rx_beat,
    input  logic                i_rx_beat_valid,
    output logic                o_rx_beat_ready,
    input  net_pkg::chan_mask_t i_enable,
    output net_pkg::ip_hdr_t    o_chan_hdr,
    output net_pkg::chan_mask_t o_chan_hdr_valid,
    input  net_pkg::chan_mask_t i_chan_hdr_ready,
    output net_pkg::ip_beat_t   o_chan_beat,
    output net_pkg::chan_mask_t o_chan_beat_valid,
    input  net_pkg::chan_mask_t i_chan_beat_ready,
    output logic                o_drop
);

    net_pkg::demux_state_t state_q;
    net_pkg::ip_hdr_t      hdr_q;
    net_pkg::chan_sel_t    sel_q;
    net_pkg::chan_sel_t    rx_sel;
    logic                  rx_known;
    logic                  rx_drop;
    logic                  drop_q;

    // protocol number to channel
    always_comb begin
        rx_known = 1'b1;
        case (i_rx_hdr.protocol)
            `NET_PROTO_TCP:  rx_sel = 2'd0;
            `NET_PROTO_UDP:  rx_sel = 2'd1;
            `NET_PROTO_ICMP: rx_sel = 2'd2;
            default: begin
                rx_sel   = 2'd0;
                rx_known = 1'b0;
            end
        endcase
        rx_drop = !rx_known || !i_enable[rx_sel];
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= net_pkg::IDLE;
            sel_q   <= '0;
            drop_q  <= 1'b0;
        end else begin
            drop_q <= 1'b0;
            case (state_q)
                net_pkg::IDLE: begin
                    if (i_rx_hdr_valid) begin
                        sel_q   <= rx_sel;
                        drop_q  <= rx_drop;
                        state_q <= rx_drop ? net_pkg::DROP : net_pkg::DELIVER;
                    end
                end
                net_pkg::DELIVER: begin
                    if (i_chan_hdr_ready[sel_q]) state_q <= net_pkg::ROUTE;
                end
                net_pkg::ROUTE: begin
                    if (i_rx_beat_valid && i_chan_beat_ready[sel_q] && i_rx_beat.last) begin
                        state_q <= net_pkg::IDLE;
                    end
                end
                default: begin // DROP, swallow beats up to the last one
                    if (i_rx_beat_valid && i_rx_beat.last) state_q <= net_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == net_pkg::IDLE && i_rx_hdr_valid) hdr_q <= i_rx_hdr;
    end

    always_comb begin
        o_chan_hdr_valid  = '0;
        o_chan_beat_valid = '0;
        o_rx_beat_ready   = 1'b0;
        case (state_q)
            net_pkg::DELIVER: o_chan_hdr_valid[sel_q] = 1'b1;
            net_pkg::ROUTE: begin
                o_chan_beat_valid[sel_q] = i_rx_beat_valid;
                o_rx_beat_ready          = i_chan_beat_ready[sel_q];
            end
            net_pkg::DROP: o_rx_beat_ready = 1'b1;
            default: ;
        endcase
    end

    assign o_rx_hdr_ready = (state_q == net_pkg::IDLE);
    assign o_chan_hdr     = hdr_q;
    assign o_chan_beat    = i_rx_beat;  // beats pass straight through
    assign o_drop         = drop_q;

endmodule

// ==== proto_channel.sv ====
`timescale 1ns/100ps
`include "net_params.svh"

module proto_channel (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  net_pkg::ip_hdr_t     i_hdr,
    input  logic                 i_hdr_valid,
    output logic                 o_hdr_ready,
    input  net_pkg::ip_beat_t    i_beat,
    input  logic                 i_beat_valid,
    output logic                 o_beat_ready,
    output net_pkg::ip_hdr_t     o_out_hdr,
    output logic                 o_out_hdr_valid,
    input  logic                 i_out_hdr_ready,
    output net_pkg::ip_beat_t    o_out_beat,
    output logic                 o_out_beat_valid,
    input  logic                 i_out_beat_ready,
    output net_pkg::chan_stats_t o_stats
);

    localparam int DEPTH = `NET_CHAN_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    net_pkg::ip_hdr_t     hdr_q;
    logic                 hdr_full_q;
    net_pkg::ip_beat_t    mem [DEPTH];
    logic [AW-1:0]        wr_ptr_q;
    logic [AW-1:0]        rd_ptr_q;
    logic [AW:0]          count_q;
    net_pkg::chan_stats_t stats_q;
    logic                 hdr_in;
    logic                 beat_in;
    logic                 beat_out;

    assign hdr_in   = i_hdr_valid && o_hdr_ready;
    assign beat_in  = i_beat_valid && o_beat_ready;
    assign beat_out = o_out_beat_valid && i_out_beat_ready;

    // one-entry header slot
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            hdr_full_q <= 1'b0;
        end else if (hdr_in) begin
            hdr_full_q <= 1'b1;
        end else if (i_out_hdr_ready) begin
            hdr_full_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (hdr_in) hdr_q <= i_hdr;
        if (beat_in) mem[wr_ptr_q] <= i_beat;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            stats_q  <= '0;
        end else begin
            if (beat_in) wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (beat_out) rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            count_q <= count_q + (AW + 1)'(beat_in) - (AW + 1)'(beat_out);
            if (hdr_in) stats_q.pkt_count <= stats_q.pkt_count + 1'b1;
            if (beat_in) stats_q.byte_count <= stats_q.byte_count + 1'b1;
        end
    end

    assign o_hdr_ready      = !hdr_full_q;
    assign o_beat_ready     = (count_q != (AW + 1)'(DEPTH));  // full fifo stalls the demux
    assign o_out_hdr        = hdr_q;
    assign o_out_hdr_valid  = hdr_full_q;
    assign o_out_beat       = mem[rd_ptr_q];
    assign o_out_beat_valid = (count_q != '0);
    assign o_stats          = stats_q;

endmodule

// ==== ip_tx_arbiter.sv ====
`timescale 1ns/100ps
`include "net_params.svh"

module ip_tx_arbiter (
    input  logic                i_clk,
    input  logic                i_reset,
    input  net_pkg::ip_hdr_t    i_chan_hdr [`NET_NUM_CHANNELS],
    input  net_pkg::chan_mask_t i_chan_hdr_valid,
    output net_pkg::chan_mask_t o_chan_hdr_ready,
    input  net_pkg::ip_beat_t   i_chan_beat [`NET_NUM_CHANNELS],
    input  net_pkg::chan_mask_t i_chan_beat_valid,
    output net_pkg::chan_mask_t o_chan_beat_ready,
    output net_pkg::ip_hdr_t    o_tx_hdr,
    output logic                o_tx_hdr_valid,
    input  logic                i_tx_hdr_ready,
    output net_pkg::ip_beat_t   o_tx_beat,
    output logic                o_tx_beat_valid,
    input  logic                i_tx_beat_ready
);

    net_pkg::arb_state_t state_q;
    net_pkg::chan_sel_t  grant_q;    // also the round-robin pointer
    logic                granted_q;
    net_pkg::chan_sel_t  pick;
    logic                pick_vld;

    // nearest pending channel after the last grant, scanned far to near
    always_comb begin
        int idx;
        pick     = grant_q;
        pick_vld = 1'b0;
        for (int i = `NET_NUM_CHANNELS; i >= 1; i--) begin
            idx = (int'(grant_q) + i) % `NET_NUM_CHANNELS;
            if (i_chan_hdr_valid[idx]) begin
                pick     = net_pkg::chan_sel_t'(idx);
                pick_vld = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q   <= net_pkg::HDR;
            grant_q   <= net_pkg::chan_sel_t'(`NET_NUM_CHANNELS - 1);
            granted_q <= 1'b0;
        end else begin
            case (state_q)
                net_pkg::HDR: begin
                    if (!granted_q) begin
                        if (pick_vld) begin
                            grant_q   <= pick;
                            granted_q <= 1'b1;
                        end
                    end else if (o_tx_hdr_valid && i_tx_hdr_ready) begin
                        state_q <= net_pkg::PAYLOAD;
                    end
                end
                default: begin
                    if (o_tx_beat_valid && i_tx_beat_ready && o_tx_beat.last) begin
                        state_q   <= net_pkg::HDR;
                        granted_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    assign o_tx_hdr        = i_chan_hdr[grant_q];
    assign o_tx_hdr_valid  = (state_q == net_pkg::HDR) && granted_q && i_chan_hdr_valid[grant_q];
    assign o_tx_beat       = i_chan_beat[grant_q];
    assign o_tx_beat_valid = (state_q == net_pkg::PAYLOAD) && i_chan_beat_valid[grant_q];

    always_comb begin
        o_chan_hdr_ready           = '0;
        o_chan_beat_ready          = '0;
        o_chan_hdr_ready[grant_q]  = (state_q == net_pkg::HDR) && granted_q && i_tx_hdr_ready;
        o_chan_beat_ready[grant_q] = (state_q == net_pkg::PAYLOAD) && i_tx_beat_ready;
    end

endmodule

// ==== net_regfile.sv ====
`timescale 1ns/100ps
`include "net_params.svh"

module net_regfile (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_psel,
    input  logic                 i_penable,
    input  logic                 i_pwrite,
    input  logic [7:0]           i_paddr,
    input  logic [31:0]          i_pwdata,
    output logic [31:0]          o_prdata,
    output logic                 o_pready,
    output logic                 o_pslverr,
    input  net_pkg::chan_stats_t i_stats [`NET_NUM_CHANNELS],
    input  logic                 i_drop,
    output net_pkg::chan_mask_t  o_enable
);

    net_pkg::chan_mask_t ctrl_q;
    net_pkg::counter_t   drop_cnt_q;
    logic                access;
    logic                mapped;
    logic [7:0]          pkt_addr;

    assign access = i_psel && i_penable;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ctrl_q     <= '1;  // all channels enabled
            drop_cnt_q <= '0;
        end else begin
            if (access && i_pwrite && i_paddr == `NET_REG_CTRL) ctrl_q <= i_pwdata[2:0];
            if (i_drop) drop_cnt_q <= drop_cnt_q + 1'b1;
        end
    end

    // read mux and address decode, writes to counters are dropped
    always_comb begin
        o_prdata = '0;
        mapped   = 1'b0;
        pkt_addr = '0;
        if (i_paddr == `NET_REG_CTRL) begin
            o_prdata = {29'b0, ctrl_q};
            mapped   = 1'b1;
        end else if (i_paddr == `NET_REG_DROP) begin
            o_prdata = drop_cnt_q;
            mapped   = 1'b1;
        end
        for (int n = 0; n < `NET_NUM_CHANNELS; n++) begin
            pkt_addr = 8'(`NET_REG_CHAN_BASE + `NET_REG_CHAN_STRIDE * n);
            if (i_paddr == pkt_addr) begin
                o_prdata = i_stats[n].pkt_count;
                mapped   = 1'b1;
            end else if (i_paddr == pkt_addr + 8'd4) begin
                o_prdata = i_stats[n].byte_count;
                mapped   = 1'b1;
            end
        end
    end

    assign o_pready  = access;  // no wait states
    assign o_pslverr = access && !mapped;
    assign o_enable  = ctrl_q;

endmodule

// ==== network_processor.sv ====
`timescale 1ns/100ps
`include "net_params.svh"

module network_processor (
    input  logic              i_clk,
    input  logic              i_reset,

    input  net_pkg::ip_hdr_t  i_rx_hdr,
    input  logic              i_rx_hdr_valid,
    output logic              o_rx_hdr_ready,
    input  net_pkg::ip_beat_t i_rx_beat,
    input  logic              i_rx_beat_valid,
    output logic              o_rx_beat_ready,

    output net_pkg::ip_hdr_t  o_tx_hdr,
    output logic              o_tx_hdr_valid,
    input  logic              i_tx_hdr_ready,
    output net_pkg::ip_beat_t o_tx_beat,
    output logic              o_tx_beat_valid,
    input  logic              i_tx_beat_ready,

    input  logic              i_psel,
    input  logic              i_penable,
    input  logic              i_pwrite,
    input  logic [7:0]        i_paddr,
    input  logic [31:0]       i_pwdata,
    output logic [31:0]       o_prdata,
    output logic              o_pready,
    output logic              o_pslverr
);

    // demux to channels
    net_pkg::ip_hdr_t     dmx_hdr;
    net_pkg::chan_mask_t  dmx_hdr_valid;
    net_pkg::chan_mask_t  dmx_hdr_ready;
    net_pkg::ip_beat_t    dmx_beat;
    net_pkg::chan_mask_t  dmx_beat_valid;
    net_pkg::chan_mask_t  dmx_beat_ready;

    // channels to arbiter
    net_pkg::ip_hdr_t     arb_hdr [`NET_NUM_CHANNELS];
    net_pkg::chan_mask_t  arb_hdr_valid;
    net_pkg::chan_mask_t  arb_hdr_ready;
    net_pkg::ip_beat_t    arb_beat [`NET_NUM_CHANNELS];
    net_pkg::chan_mask_t  arb_beat_valid;
    net_pkg::chan_mask_t  arb_beat_ready;

    net_pkg::chan_stats_t chan_stats [`NET_NUM_CHANNELS];
    net_pkg::chan_mask_t  enable;
    logic                 drop;

    ip_proto_demux u_ip_proto_demux (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_rx_hdr          (i_rx_hdr),
        .i_rx_hdr_valid    (i_rx_hdr_valid),
        .o_rx_hdr_ready    (o_rx_hdr_ready),
        .i_rx_beat         (i_rx_beat),
        .i_rx_beat_valid   (i_rx_beat_valid),
        .o_rx_beat_ready   (o_rx_beat_ready),
        .i_enable          (enable),
        .o_chan_hdr        (dmx_hdr),
        .o_chan_hdr_valid  (dmx_hdr_valid),
        .i_chan_hdr_ready  (dmx_hdr_ready),
        .o_chan_beat       (dmx_beat),
        .o_chan_beat_valid (dmx_beat_valid),
        .i_chan_beat_ready (dmx_beat_ready),
        .o_drop            (drop)
    );

    for (genvar n = 0; n < `NET_NUM_CHANNELS; n++) begin : g_chan
        proto_channel u_proto_channel (
            .i_clk            (i_clk),
            .i_reset          (i_reset),
            .i_hdr            (dmx_hdr),
            .i_hdr_valid      (dmx_hdr_valid[n]),
            .o_hdr_ready      (dmx_hdr_ready[n]),
            .i_beat           (dmx_beat),
            .i_beat_valid     (dmx_beat_valid[n]),
            .o_beat_ready     (dmx_beat_ready[n]),
            .o_out_hdr        (arb_hdr[n]),
            .o_out_hdr_valid  (arb_hdr_valid[n]),
            .i_out_hdr_ready  (arb_hdr_ready[n]),
            .o_out_beat       (arb_beat[n]),
            .o_out_beat_valid (arb_beat_valid[n]),
            .i_out_beat_ready (arb_beat_ready[n]),
            .o_stats          (chan_stats[n])
        );
    end

    ip_tx_arbiter u_ip_tx_arbiter (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_chan_hdr        (arb_hdr),
        .i_chan_hdr_valid  (arb_hdr_valid),
        .o_chan_hdr_ready  (arb_hdr_ready),
        .i_chan_beat       (arb_beat),
        .i_chan_beat_valid (arb_beat_valid),
        .o_chan_beat_ready (arb_beat_ready),
        .o_tx_hdr          (o_tx_hdr),
        .o_tx_hdr_valid    (o_tx_hdr_valid),
        .i_tx_hdr_ready    (i_tx_hdr_ready),
        .o_tx_beat         (o_tx_beat),
        .o_tx_beat_valid   (o_tx_beat_valid),
        .i_tx_beat_ready   (i_tx_beat_ready)
    );

    net_regfile u_net_regfile (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .i_stats   (chan_stats),
        .i_drop    (drop),
        .o_enable  (enable)
    );

endmodule

// ==== tb_network_processor.sv ====
`timescale 1ns/100ps
`include "net_params.svh"

module tb_network_processor;

    localparam int TIMEOUT = 1000;  // cycles allowed for any single wait

    logic              i_clk = 1'b0;
    logic              i_reset;
    net_pkg::ip_hdr_t  i_rx_hdr;
    logic              i_rx_hdr_valid;
    logic              o_rx_hdr_ready;
    net_pkg::ip_beat_t i_rx_beat;
    logic              i_rx_beat_valid;
    logic              o_rx_beat_ready;
    net_pkg::ip_hdr_t  o_tx_hdr;
    logic              o_tx_hdr_valid;
    logic              i_tx_hdr_ready;
    net_pkg::ip_beat_t o_tx_beat;
    logic              o_tx_beat_valid;
    logic              i_tx_beat_ready;
    logic              i_psel;
    logic              i_penable;
    logic              i_pwrite;
    logic [7:0]        i_paddr;
    logic [31:0]       i_pwdata;
    logic [31:0]       o_prdata;
    logic              o_pready;
    logic              o_pslverr;

    // packets waiting to be sent in order
    net_pkg::ip_hdr_t stim_hdr [$];
    int               stim_len [$];
    net_pkg::byte_t   stim_data [$];
    // scoreboard with one set of queues per channel
    net_pkg::ip_hdr_t exp_hdr [`NET_NUM_CHANNELS][$];
    int               exp_len [`NET_NUM_CHANNELS][$];
    net_pkg::byte_t   exp_data [`NET_NUM_CHANNELS][$];
    int               sent_pkts [`NET_NUM_CHANNELS] = '{default: 0};
    int               sent_bytes [`NET_NUM_CHANNELS] = '{default: 0};
    int               drops_model = 0;
    logic [2:0]       enable_model = 3'b111;
    logic [31:0]      lfsr_q = 32'd74885;
    bit               rand_ready = 1'b0;  // tx readies follow the lfsr when set

    network_processor i_dut (.*);

    always #2 i_clk = ~i_clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    // routing rule gives -1 for protocols without a channel
    function automatic int chan_of(input net_pkg::ip_proto_t proto);
        case (proto)
            `NET_PROTO_TCP:  return 0;
            `NET_PROTO_UDP:  return 1;
            `NET_PROTO_ICMP: return 2;
            default:         return -1;
        endcase
    endfunction

    function automatic logic [7:0] chan_reg(input int n, input bit bytes);
        return 8'(`NET_REG_CHAN_BASE + `NET_REG_CHAN_STRIDE * n + (bytes ? 4 : 0));
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [95:0] got,
                               input logic [95:0] exp);
        assert (got === exp) else
            fail_now($sformatf("Mismatch at %0t: %s got %0h expected %0h",
                               $time, what, got, exp));
    endtask

    task automatic step();
        @(posedge i_clk);
        #1;
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int cycles;
        cycles    = 0;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        step();
        i_penable = 1'b1;  // access phase
        @(negedge i_clk);
        while (!o_pready) begin
            cycles++;
            if (cycles > TIMEOUT) fail_now("timeout waiting for APB pready");
            @(negedge i_clk);
        end
        rdata = o_prdata;
        err   = o_pslverr;
        step();
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] rdata;
        apb_access(1'b1, addr, data, rdata, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_value("pslverr on register read", 96'(err), 96'(0));
        check_value(what, 96'(data), 96'(exp));
    endtask

    task automatic write_ctrl(input logic [2:0] mask);
        logic err;
        apb_write(`NET_REG_CTRL, 32'(mask), err);
        check_value("pslverr on CTRL write", 96'(err), 96'(0));
        enable_model = mask;
    endtask

    // queue one packet and record what should come out of tx
    task automatic make_packet(input net_pkg::ip_proto_t proto, input int len);
        net_pkg::ip_hdr_t hdr;
        net_pkg::byte_t   b;
        int               ch;
        bit               passes;
        hdr.protocol  = proto;
        hdr.ttl       = 8'(rand_bits(8));
        hdr.length    = 16'(20 + len);
        hdr.source_ip = rand_bits(32);
        hdr.dest_ip   = rand_bits(32);
        ch     = chan_of(proto);
        passes = 1'b0;
        if (ch >= 0) passes = enable_model[ch];
        stim_hdr.push_back(hdr);
        stim_len.push_back(len);
        if (passes) begin
            exp_hdr[ch].push_back(hdr);
            exp_len[ch].push_back(len);
            sent_pkts[ch]++;
            sent_bytes[ch] += len;
        end else begin
            drops_model++;
        end
        for (int i = 0; i < len; i++) begin
            b = 8'(rand_bits(8));
            stim_data.push_back(b);
            if (passes) exp_data[ch].push_back(b);
        end
    endtask

    task automatic send_packet();
        int len;
        int cycles;
        len            = stim_len.pop_front();
        i_rx_hdr       = stim_hdr.pop_front();
        i_rx_hdr_valid = 1'b1;
        cycles         = 0;
        @(negedge i_clk);
        while (!o_rx_hdr_ready) begin
            cycles++;
            if (cycles > TIMEOUT) fail_now("timeout waiting for rx header ready");
            @(negedge i_clk);
        end
        step();
        i_rx_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            i_rx_beat.data  = stim_data.pop_front();
            i_rx_beat.last  = (i == len - 1);
            i_rx_beat_valid = 1'b1;
            cycles          = 0;
            @(negedge i_clk);
            while (!o_rx_beat_ready) begin
                cycles++;
                if (cycles > TIMEOUT) fail_now("timeout waiting for rx beat ready");
                @(negedge i_clk);
            end
            step();
        end
        i_rx_beat_valid = 1'b0;
    endtask

    task automatic recv_packet();
        net_pkg::ip_hdr_t hdr;
        int               ch;
        int               len;
        int               cycles;
        bit               done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            i_tx_hdr_ready = rand_ready ? lfsr_bit() : 1'b1;
            @(negedge i_clk);
            if (o_tx_hdr_valid && i_tx_hdr_ready) begin
                hdr  = o_tx_hdr;
                done = 1'b1;
            end else begin
                cycles++;
                if (cycles > TIMEOUT) fail_now("timeout waiting for a tx header");
            end
            step();
        end
        i_tx_hdr_ready = 1'b0;
        ch = chan_of(hdr.protocol);
        assert (ch >= 0 && exp_hdr[ch].size() > 0) else
            fail_now($sformatf("unexpected packet with protocol %0d at tx", hdr.protocol));
        check_value("tx header", 96'(hdr), 96'(exp_hdr[ch].pop_front()));
        len = exp_len[ch].pop_front();
        for (int i = 0; i < len; i++) begin
            cycles = 0;
            done   = 1'b0;
            while (!done) begin
                i_tx_beat_ready = rand_ready ? lfsr_bit() : 1'b1;
                @(negedge i_clk);
                if (o_tx_beat_valid && i_tx_beat_ready) begin
                    check_value("tx beat data", 96'(o_tx_beat.data),
                                96'(exp_data[ch].pop_front()));
                    check_value("tx beat last", 96'(o_tx_beat.last), 96'(i == len - 1));
                    done = 1'b1;
                end else begin
                    cycles++;
                    if (cycles > TIMEOUT) fail_now("timeout waiting for a tx beat");
                end
                step();
            end
        end
        i_tx_beat_ready = 1'b0;
    endtask

    // send everything queued while draining what should arrive
    task automatic run_traffic();
        int n_send;
        int n_recv;
        n_send = stim_hdr.size();
        n_recv = 0;
        for (int n = 0; n < `NET_NUM_CHANNELS; n++) n_recv += exp_hdr[n].size();
        fork
            for (int i = 0; i < n_send; i++) send_packet();
            for (int i = 0; i < n_recv; i++) recv_packet();
        join
    endtask

    task automatic test_reset_values();
        logic [31:0] data;
        logic        err;
        check_value("rx header ready after reset", 96'(o_rx_hdr_ready), 96'(1));
        check_value("tx header valid after reset", 96'(o_tx_hdr_valid), 96'(0));
        check_value("tx beat valid after reset", 96'(o_tx_beat_valid), 96'(0));
        check_reg(`NET_REG_CTRL, 32'd7, "CTRL after reset");
        check_reg(`NET_REG_DROP, 32'd0, "DROP after reset");
        for (int n = 0; n < `NET_NUM_CHANNELS; n++) begin
            check_reg(chan_reg(n, 1'b0), 32'd0, $sformatf("PKT%0d after reset", n));
            check_reg(chan_reg(n, 1'b1), 32'd0, $sformatf("BYTE%0d after reset", n));
        end
        apb_read(8'h08, data, err);
        check_value("pslverr on unmapped read", 96'(err), 96'(1));
        check_value("data on unmapped read", 96'(data), 96'(0));
        apb_write(chan_reg(0, 1'b0), 32'h55, err);
        check_value("pslverr on PKT write", 96'(err), 96'(0));
        check_reg(chan_reg(0, 1'b0), 32'd0, "PKT0 after write");
    endtask

    task automatic test_routing();
        make_packet(`NET_PROTO_TCP, 5);
        make_packet(`NET_PROTO_UDP, 1);
        make_packet(`NET_PROTO_ICMP, 9);
        run_traffic();
    endtask

    task automatic test_unknown_proto();
        make_packet(8'd99, 4);
        make_packet(`NET_PROTO_TCP, 3);
        run_traffic();
        check_reg(`NET_REG_DROP, 32'(drops_model), "DROP after unknown protocol");
    endtask

    task automatic test_disabled_channel();
        write_ctrl(3'b101);  // udp off
        make_packet(`NET_PROTO_UDP, 6);
        make_packet(`NET_PROTO_TCP, 2);
        make_packet(`NET_PROTO_ICMP, 4);
        make_packet(`NET_PROTO_UDP, 3);
        run_traffic();
        check_reg(`NET_REG_DROP, 32'(drops_model), "DROP with UDP disabled");
        write_ctrl(3'b111);
        make_packet(`NET_PROTO_UDP, 7);
        run_traffic();
        check_reg(`NET_REG_DROP, 32'(drops_model), "DROP with UDP enabled again");
    endtask

    task automatic test_backpressure();
        int sel;
        rand_ready = 1'b1;
        for (int i = 0; i < 12; i++) begin
            sel = int'(rand_bits(2)) % 3;
            case (sel)
                0:       make_packet(`NET_PROTO_TCP, 1 + int'(rand_bits(5)));
                1:       make_packet(`NET_PROTO_UDP, 1 + int'(rand_bits(5)));
                default: make_packet(`NET_PROTO_ICMP, 1 + int'(rand_bits(5)));
            endcase
        end
        run_traffic();
        rand_ready = 1'b0;
        for (int n = 0; n < `NET_NUM_CHANNELS; n++) begin
            check_reg(chan_reg(n, 1'b0), 32'(sent_pkts[n]), $sformatf("PKT%0d", n));
            check_reg(chan_reg(n, 1'b1), 32'(sent_bytes[n]), $sformatf("BYTE%0d", n));
        end
    endtask

    initial begin
        i_reset         = 1'b1;
        i_rx_hdr        = '0;
        i_rx_hdr_valid  = 1'b0;
        i_rx_beat       = '0;
        i_rx_beat_valid = 1'b0;
        i_tx_hdr_ready  = 1'b0;
        i_tx_beat_ready = 1'b0;
        i_psel          = 1'b0;
        i_penable       = 1'b0;
        i_pwrite        = 1'b0;
        i_paddr         = '0;
        i_pwdata        = '0;
        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        test_reset_values();
        test_routing();
        test_unknown_proto();
        test_disabled_channel();
        test_backpressure();
        repeat (8) step();
        // a packet that was never expected would now be waiting at tx
        if (!o_tx_hdr_valid) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            fail_now("an unexpected packet is waiting at tx at the end of the run");
        end
    end

endmodule

// ==== src.f ====
+incdir+.
net_pkg.sv
ip_proto_demux.sv
proto_channel.sv
ip_tx_arbiter.sv
net_regfile.sv
network_processor.sv
tb_network_processor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_network_processor
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
